//--- verilog/mac_frame_pkg.sv
package mac_frame_pkg;

    localparam int COUNT_W_DEFAULT = 11;              // Byte counts up to 2047
    localparam int N_SLOTS         = 2;               // Receive slots
    localparam int SLOT_W          = $clog2(N_SLOTS);

    typedef logic [SLOT_W-1:0]  slot_t;               // Receive slot index
    typedef logic [N_SLOTS-1:0] slot_vec_t;           // One bit per receive slot

endpackage

//--- verilog/mac_ctrl_pkg.sv
package mac_ctrl_pkg;

    // Host side transmit handshake
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT_DONE,
        TX_ACK
    } host_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_FRAME,
        RX_FINISH                                     // Done pulse cycle
    } rx_state_t;

    typedef enum logic [1:0] {
        TXE_IDLE,
        TXE_SEND,
        TXE_DONE
    } tx_state_t;

endpackage

//--- verilog/mac_pulse_sync.sv
`timescale 1ns/1ps

module mac_pulse_sync (
    input  logic clk_src,
    input  logic clk_dst,
    input  logic arst_n,
    input  logic pulse_in,
    output logic pulse_out
);

    logic       src_toggle;                           // Flips once per source pulse
    logic [2:0] dst_sync;

    always_ff @(posedge clk_src or negedge arst_n) begin
        if (!arst_n) begin
            src_toggle <= 1'b0;
        end else if (pulse_in) begin
            src_toggle <= ~src_toggle;
        end
    end

    always_ff @(posedge clk_dst or negedge arst_n) begin
        if (!arst_n) begin
            dst_sync <= '0;
        end else begin
            dst_sync <= {dst_sync[1:0], src_toggle};  // Bit 0 may go metastable
        end
    end

    assign pulse_out = dst_sync[2] ^ dst_sync[1];     // One cycle per toggle edge

endmodule

//--- verilog/mac_domain_sync.sv
`timescale 1ns/1ps

module mac_domain_sync #(
    parameter int COUNT_W = mac_frame_pkg::COUNT_W_DEFAULT
) (
    input  logic                     clk2,
    input  logic                     phy_rx_clk,
    input  logic                     phy_tx_clk,
    input  logic                     arst_n,
    input  mac_frame_pkg::slot_vec_t sys_rx_ready,
    output mac_frame_pkg::slot_vec_t sys_rx_done,
    output logic [COUNT_W-1:0]       sys_rx_count_0,
    output logic [COUNT_W-1:0]       sys_rx_count_1,
    input  logic                     sys_tx_start,
    output logic                     sys_tx_done,
    input  logic [COUNT_W-1:0]       sys_tx_count,
    output mac_frame_pkg::slot_vec_t phy_rx_ready,
    input  mac_frame_pkg::slot_vec_t phy_rx_done,
    input  logic [COUNT_W-1:0]       phy_rx_count_0,
    input  logic [COUNT_W-1:0]       phy_rx_count_1,
    output logic                     phy_tx_start,
    input  logic                     phy_tx_done,
    output logic [COUNT_W-1:0]       phy_tx_count
);

    logic [COUNT_W-1:0] rx_count_0_meta;
    logic [COUNT_W-1:0] rx_count_1_meta;
    logic [COUNT_W-1:0] tx_count_meta;

    for (genvar i = 0; i < mac_frame_pkg::N_SLOTS; i++) begin : g_slot
        mac_pulse_sync u_rx_ready (
            .clk_src(clk2), .clk_dst(phy_rx_clk), .arst_n(arst_n),
            .pulse_in(sys_rx_ready[i]), .pulse_out(phy_rx_ready[i])
        );
        mac_pulse_sync u_rx_done (
            .clk_src(phy_rx_clk), .clk_dst(clk2), .arst_n(arst_n),
            .pulse_in(phy_rx_done[i]), .pulse_out(sys_rx_done[i])
        );
    end

    mac_pulse_sync u_tx_start (
        .clk_src(clk2), .clk_dst(phy_tx_clk), .arst_n(arst_n),
        .pulse_in(sys_tx_start), .pulse_out(phy_tx_start)
    );
    mac_pulse_sync u_tx_done (
        .clk_src(phy_tx_clk), .clk_dst(clk2), .arst_n(arst_n),
        .pulse_in(phy_tx_done), .pulse_out(sys_tx_done)
    );

    // Counts settle well before the matching pulse leaves its synchronizer
    always_ff @(posedge clk2) begin
        rx_count_0_meta <= phy_rx_count_0;
        sys_rx_count_0  <= rx_count_0_meta;
        rx_count_1_meta <= phy_rx_count_1;
        sys_rx_count_1  <= rx_count_1_meta;
    end

    always_ff @(posedge phy_tx_clk) begin
        tx_count_meta <= sys_tx_count;
        phy_tx_count  <= tx_count_meta;
    end

endmodule

//--- verilog/mac_rx_engine.sv
`timescale 1ns/1ps

module mac_rx_engine #(
    parameter int COUNT_W = mac_frame_pkg::COUNT_W_DEFAULT
) (
    input  logic                     phy_rx_clk,
    input  logic                     arst_n,
    input  logic                     phy_rx_valid,
    input  logic                     phy_rx_last,
    input  mac_frame_pkg::slot_vec_t rx_ready,
    output mac_frame_pkg::slot_vec_t rx_done,
    output logic [COUNT_W-1:0]       rx_count_0,
    output logic [COUNT_W-1:0]       rx_count_1
);

    mac_ctrl_pkg::rx_state_t  state;
    mac_frame_pkg::slot_vec_t armed;
    mac_frame_pkg::slot_vec_t disarm;
    mac_frame_pkg::slot_t     cur_slot;
    mac_frame_pkg::slot_t     pick_slot;
    mac_frame_pkg::slot_t     byte_slot;
    logic                     drop;                   // Frame had no armed slot
    logic                     frame_start;
    logic                     byte_take;

    assign pick_slot   = armed[0] ? 1'b0 : 1'b1;      // Lowest armed slot
    assign frame_start = phy_rx_valid && (state != mac_ctrl_pkg::RX_FRAME);
    assign byte_take   = phy_rx_valid && (frame_start ? |armed : !drop);
    assign byte_slot   = frame_start ? pick_slot : cur_slot;
    assign disarm      = (byte_take && phy_rx_last) ?
                         (mac_frame_pkg::slot_vec_t'(1) << byte_slot) : '0;
    assign rx_done     = (state == mac_ctrl_pkg::RX_FINISH) ?
                         (mac_frame_pkg::slot_vec_t'(1) << cur_slot) : '0;

    always_ff @(posedge phy_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= mac_ctrl_pkg::RX_IDLE;
            armed    <= '0;
            cur_slot <= '0;
            drop     <= 1'b0;
        end else begin
            armed <= (armed | rx_ready) & ~disarm;
            if (phy_rx_valid) begin
                if (frame_start) begin
                    cur_slot <= pick_slot;
                    drop     <= ~|armed;
                end
                if (phy_rx_last) begin
                    state <= byte_take ? mac_ctrl_pkg::RX_FINISH : mac_ctrl_pkg::RX_IDLE;
                end else begin
                    state <= mac_ctrl_pkg::RX_FRAME;
                end
            end else if (state == mac_ctrl_pkg::RX_FINISH) begin
                state <= mac_ctrl_pkg::RX_IDLE;
            end
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        if (byte_take && byte_slot == 1'b0) begin
            rx_count_0 <= frame_start ? COUNT_W'(1) : rx_count_0 + COUNT_W'(1);
        end
        if (byte_take && byte_slot == 1'b1) begin
            rx_count_1 <= frame_start ? COUNT_W'(1) : rx_count_1 + COUNT_W'(1);
        end
    end

endmodule

//--- verilog/mac_tx_engine.sv
`timescale 1ns/1ps

module mac_tx_engine #(
    parameter int COUNT_W = mac_frame_pkg::COUNT_W_DEFAULT
) (
    input  logic               phy_tx_clk,
    input  logic               arst_n,
    input  logic               tx_start,
    input  logic [COUNT_W-1:0] tx_count,
    output logic               phy_tx_valid,
    output logic               tx_done
);

    mac_ctrl_pkg::tx_state_t state;
    logic [COUNT_W-1:0]      remain;                  // Bytes still to strobe

    assign phy_tx_valid = (state == mac_ctrl_pkg::TXE_SEND);
    assign tx_done      = (state == mac_ctrl_pkg::TXE_DONE);

    always_ff @(posedge phy_tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= mac_ctrl_pkg::TXE_IDLE;
            remain <= '0;
        end else begin
            unique case (state)
                mac_ctrl_pkg::TXE_IDLE: begin
                    if (tx_start) begin
                        remain <= tx_count;
                        state  <= (tx_count == '0) ? mac_ctrl_pkg::TXE_DONE
                                                   : mac_ctrl_pkg::TXE_SEND;
                    end
                end
                mac_ctrl_pkg::TXE_SEND: begin
                    remain <= remain - COUNT_W'(1);
                    if (remain == COUNT_W'(1)) state <= mac_ctrl_pkg::TXE_DONE;
                end
                default: state <= mac_ctrl_pkg::TXE_IDLE;  // TXE_DONE lasts one cycle
            endcase
        end
    end

endmodule

//--- verilog/mac_host_ctrl.sv
`timescale 1ns/1ps

module mac_host_ctrl #(
    parameter int COUNT_W = mac_frame_pkg::COUNT_W_DEFAULT
) (
    input  logic                     clk2,
    input  logic                     arst_n,
    input  logic                     arm_req,
    input  mac_frame_pkg::slot_t     arm_slot,
    output logic                     arm_ack,
    output logic                     frame_req,
    input  logic                     frame_ack,
    output mac_frame_pkg::slot_t     frame_slot,
    output logic [COUNT_W-1:0]       frame_count,
    input  logic                     tx_req,
    input  logic [COUNT_W-1:0]       tx_count,
    output logic                     tx_ack,
    output mac_frame_pkg::slot_vec_t rx_ready,
    input  mac_frame_pkg::slot_vec_t rx_done,
    input  logic [COUNT_W-1:0]       rx_count_0,
    input  logic [COUNT_W-1:0]       rx_count_1,
    output logic                     tx_start,
    input  logic                     tx_done,
    output logic [COUNT_W-1:0]       sys_tx_count
);

    mac_ctrl_pkg::host_state_t tx_state;
    mac_frame_pkg::slot_vec_t  pending;               // Done seen, not yet reported
    mac_frame_pkg::slot_vec_t  take_vec;
    mac_frame_pkg::slot_t      take_slot;
    logic                      frame_take;
    logic                      arm_req_q;
    logic                      tx_req_q;
    logic                      tx_launch;

    assign take_slot  = pending[0] ? 1'b0 : 1'b1;     // Slot 0 wins
    assign frame_take = !frame_req && !frame_ack && (|pending);
    assign take_vec   = frame_take ? (mac_frame_pkg::slot_vec_t'(1) << take_slot) : '0;
    assign tx_launch  = (tx_state == mac_ctrl_pkg::TX_IDLE) && tx_req && !tx_req_q;
    assign tx_ack     = (tx_state == mac_ctrl_pkg::TX_ACK);

    always_ff @(posedge clk2 or negedge arst_n) begin
        if (!arst_n) begin
            arm_req_q <= 1'b0;
            rx_ready  <= '0;
            arm_ack   <= 1'b0;
            pending   <= '0;
            frame_req <= 1'b0;
        end else begin
            arm_req_q <= arm_req;
            rx_ready  <= (arm_req && !arm_req_q) ?
                         (mac_frame_pkg::slot_vec_t'(1) << arm_slot) : '0;
            if (|rx_ready) arm_ack <= 1'b1;           // Cycle after the ready pulse
            else if (!arm_req) arm_ack <= 1'b0;
            pending <= (pending | rx_done) & ~take_vec;
            if (frame_take) frame_req <= 1'b1;
            else if (frame_ack) frame_req <= 1'b0;
        end
    end

    always_ff @(posedge clk2 or negedge arst_n) begin
        if (!arst_n) begin
            tx_state <= mac_ctrl_pkg::TX_IDLE;
            tx_req_q <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_req_q <= tx_req;
            tx_start <= tx_launch;
            unique case (tx_state)
                mac_ctrl_pkg::TX_IDLE:
                    if (tx_launch) tx_state <= mac_ctrl_pkg::TX_WAIT_DONE;
                mac_ctrl_pkg::TX_WAIT_DONE:
                    if (tx_done) tx_state <= mac_ctrl_pkg::TX_ACK;
                mac_ctrl_pkg::TX_ACK:
                    if (!tx_req) tx_state <= mac_ctrl_pkg::TX_IDLE;
                default: tx_state <= mac_ctrl_pkg::TX_IDLE;
            endcase
        end
    end

    // Held until the next launch, so the PHY side samples a settled value
    always_ff @(posedge clk2) begin
        if (tx_launch) sys_tx_count <= tx_count;
        if (frame_take) begin
            frame_slot  <= take_slot;
            frame_count <= take_slot ? rx_count_1 : rx_count_0;
        end
    end

endmodule

//--- verilog/mac_sync_top.sv
`timescale 1ns/1ps

module mac_sync_top #(
    parameter int COUNT_W = mac_frame_pkg::COUNT_W_DEFAULT
) (
    input  logic                 clk2,
    input  logic                 phy_rx_clk,
    input  logic                 phy_tx_clk,
    input  logic                 arst_n,
    input  logic                 arm_req,
    input  mac_frame_pkg::slot_t arm_slot,
    output logic                 arm_ack,
    output logic                 frame_req,
    input  logic                 frame_ack,
    output mac_frame_pkg::slot_t frame_slot,
    output logic [COUNT_W-1:0]   frame_count,
    input  logic                 tx_req,
    input  logic [COUNT_W-1:0]   tx_count,
    output logic                 tx_ack,
    input  logic                 phy_rx_valid,
    input  logic                 phy_rx_last,
    output logic                 phy_tx_valid
);

    mac_frame_pkg::slot_vec_t sys_rx_ready;
    mac_frame_pkg::slot_vec_t sys_rx_done;
    mac_frame_pkg::slot_vec_t phy_rx_ready;
    mac_frame_pkg::slot_vec_t phy_rx_done;
    logic [COUNT_W-1:0]       sys_rx_count_0;
    logic [COUNT_W-1:0]       sys_rx_count_1;
    logic [COUNT_W-1:0]       phy_rx_count_0;
    logic [COUNT_W-1:0]       phy_rx_count_1;
    logic [COUNT_W-1:0]       sys_tx_count;
    logic [COUNT_W-1:0]       phy_tx_count;
    logic                     sys_tx_start;
    logic                     sys_tx_done;
    logic                     phy_tx_start;
    logic                     phy_tx_done;

    mac_host_ctrl #(.COUNT_W(COUNT_W)) u_host_ctrl (
        .clk2(clk2), .arst_n(arst_n),
        .arm_req(arm_req), .arm_slot(arm_slot), .arm_ack(arm_ack),
        .frame_req(frame_req), .frame_ack(frame_ack),
        .frame_slot(frame_slot), .frame_count(frame_count),
        .tx_req(tx_req), .tx_count(tx_count), .tx_ack(tx_ack),
        .rx_ready(sys_rx_ready), .rx_done(sys_rx_done),
        .rx_count_0(sys_rx_count_0), .rx_count_1(sys_rx_count_1),
        .tx_start(sys_tx_start), .tx_done(sys_tx_done), .sys_tx_count(sys_tx_count)
    );

    mac_domain_sync #(.COUNT_W(COUNT_W)) u_domain_sync (
        .clk2(clk2), .phy_rx_clk(phy_rx_clk), .phy_tx_clk(phy_tx_clk), .arst_n(arst_n),
        .sys_rx_ready(sys_rx_ready), .sys_rx_done(sys_rx_done),
        .sys_rx_count_0(sys_rx_count_0), .sys_rx_count_1(sys_rx_count_1),
        .sys_tx_start(sys_tx_start), .sys_tx_done(sys_tx_done),
        .sys_tx_count(sys_tx_count),
        .phy_rx_ready(phy_rx_ready), .phy_rx_done(phy_rx_done),
        .phy_rx_count_0(phy_rx_count_0), .phy_rx_count_1(phy_rx_count_1),
        .phy_tx_start(phy_tx_start), .phy_tx_done(phy_tx_done),
        .phy_tx_count(phy_tx_count)
    );

    mac_rx_engine #(.COUNT_W(COUNT_W)) u_rx_engine (
        .phy_rx_clk(phy_rx_clk), .arst_n(arst_n),
        .phy_rx_valid(phy_rx_valid), .phy_rx_last(phy_rx_last),
        .rx_ready(phy_rx_ready), .rx_done(phy_rx_done),
        .rx_count_0(phy_rx_count_0), .rx_count_1(phy_rx_count_1)
    );

    mac_tx_engine #(.COUNT_W(COUNT_W)) u_tx_engine (
        .phy_tx_clk(phy_tx_clk), .arst_n(arst_n),
        .tx_start(phy_tx_start), .tx_count(phy_tx_count),
        .phy_tx_valid(phy_tx_valid), .tx_done(phy_tx_done)
    );

endmodule

//--- testbench/mac_sync_asserts.sv
`timescale 1ns/1ps

module mac_sync_asserts (
    input logic clk2,
    input logic arst_n,
    input logic arm_req,
    input logic arm_ack,
    input logic frame_req,
    input logic frame_ack,
    input logic tx_start
);

    int fail_count = 0;                               // Polled by the testbench monitor

    // The host may drop arm_req as soon as it sees arm_ack high
    arm_ack_needs_req: assert property (@(posedge clk2) disable iff (!arst_n)
        $rose(arm_ack) |-> $past(arm_req))
        else begin
            fail_count++;
            $error("arm_ack rose while arm_req was low");
        end

    // Host sees the frame until it answers
    frame_req_holds: assert property (@(posedge clk2) disable iff (!arst_n)
        (frame_req && !frame_ack) |=> frame_req)
        else begin
            fail_count++;
            $error("frame_req fell before frame_ack");
        end

    tx_start_single: assert property (@(posedge clk2) disable iff (!arst_n)
        tx_start |=> !tx_start)
        else begin
            fail_count++;
            $error("tx_start lasted more than one cycle");
        end

endmodule

//--- testbench/tb_mac_sync.sv
`timescale 1ns/1ps

module tb_mac_sync;

    localparam int    COUNT_W    = mac_frame_pkg::COUNT_W_DEFAULT;
    localparam string TRACE_FILE = "testbench/mac_sync_trace.txt";
    localparam int    DRIVE      = 2;                 // Drive and sample point after an edge

    logic                 clk2;
    logic                 phy_rx_clk;
    logic                 phy_tx_clk;
    logic                 arst_n;
    logic                 arm_req;
    mac_frame_pkg::slot_t arm_slot;
    logic                 arm_ack;
    logic                 frame_req;
    logic                 frame_ack;
    mac_frame_pkg::slot_t frame_slot;
    logic [COUNT_W-1:0]   frame_count;
    logic                 tx_req;
    logic [COUNT_W-1:0]   tx_count;
    logic                 tx_ack;
    logic                 phy_rx_valid;
    logic                 phy_rx_last;
    logic                 phy_tx_valid;

    byte         op_q[$];                             // Trace operation letters
    int          a_q[$];
    int          b_q[$];
    int          c_q[$];
    logic [31:0] lfsr;
    int          strobe_count;                        // phy_tx_valid cycles seen
    int          strobe_runs;                         // Separate bursts of phy_tx_valid
    int          limit_ns;

    initial begin
        clk2 = 1'b0;
        forever #10 clk2 = ~clk2;
    end

    initial begin
        phy_rx_clk = 1'b0;
        forever #8 phy_rx_clk = ~phy_rx_clk;
    end

    initial begin
        phy_tx_clk = 1'b0;
        forever #14 phy_tx_clk = ~phy_tx_clk;
    end

    mac_sync_top #(.COUNT_W(COUNT_W)) u_dut (
        .clk2(clk2), .phy_rx_clk(phy_rx_clk), .phy_tx_clk(phy_tx_clk), .arst_n(arst_n),
        .arm_req(arm_req), .arm_slot(arm_slot), .arm_ack(arm_ack),
        .frame_req(frame_req), .frame_ack(frame_ack),
        .frame_slot(frame_slot), .frame_count(frame_count),
        .tx_req(tx_req), .tx_count(tx_count), .tx_ack(tx_ack),
        .phy_rx_valid(phy_rx_valid), .phy_rx_last(phy_rx_last), .phy_tx_valid(phy_tx_valid)
    );

    bind mac_host_ctrl mac_sync_asserts u_asserts (
        .clk2(clk2), .arst_n(arst_n), .arm_req(arm_req), .arm_ack(arm_ack),
        .frame_req(frame_req), .frame_ack(frame_ack), .tx_start(tx_start)
    );

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        int    bytes;
        string line;
        bytes = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the trace file %s", TRACE_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                a = 0;
                b = 0;
                c = 0;
                n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c);
                op_q.push_back(line[0]);
                a_q.push_back(a);
                b_q.push_back(b);
                c_q.push_back(c);
                if (line[0] == "P") bytes += a + b;
                else if (line[0] != "A") bytes += a;
            end
        end
        $fclose(fd);
        limit_ns = 5000 + 4000 * op_q.size() + 80 * bytes;
    endtask

    task automatic sys_step();
        @(posedge clk2);
        #DRIVE;
    endtask

    task automatic arm_slot_hs(input int slot);
        sys_step();
        arm_slot = mac_frame_pkg::slot_t'(slot);
        arm_req  = 1'b1;
        while (!arm_ack) sys_step();
        arm_req = 1'b0;
        while (arm_ack) sys_step();
    endtask

    task automatic receive_bytes(input int n);
        int gap;
        repeat (8) @(posedge phy_rx_clk);             // Ready pulse reaches the PHY side
        for (int i = 0; i < n; i++) begin
            random_bits(2, gap);
            repeat (gap) begin
                @(posedge phy_rx_clk);
                #DRIVE;
                phy_rx_valid = 1'b0;
                phy_rx_last  = 1'b0;
            end
            @(posedge phy_rx_clk);
            #DRIVE;
            phy_rx_valid = 1'b1;
            phy_rx_last  = (i == n - 1);
        end
        @(posedge phy_rx_clk);
        #DRIVE;
        phy_rx_valid = 1'b0;
        phy_rx_last  = 1'b0;
    endtask

    task automatic expect_frame(input string name, input int slot, input int count,
                                input int ack_delay);
        sys_step();
        while (!frame_req) sys_step();
        check_value({name, " frame_slot"}, slot, int'(frame_slot));
        check_value({name, " frame_count"}, count, int'(frame_count));
        repeat (ack_delay) begin
            sys_step();
            check_value({name, " frame_req held"}, 1, int'(frame_req));
        end
        frame_ack = 1'b1;
        while (frame_req) sys_step();
        frame_ack = 1'b0;
    endtask

    task automatic expect_silence(input string name);
        repeat (60) begin                             // Far beyond the done crossing delay
            sys_step();
            check_value({name, " frame_req"}, 0, int'(frame_req));
        end
    endtask

    task automatic transmit_frame(input string name, input int count);
        int strobes_before;
        int runs_before;
        sys_step();
        strobes_before = strobe_count;
        runs_before    = strobe_runs;
        tx_count       = COUNT_W'(count);
        tx_req         = 1'b1;
        while (!tx_ack) sys_step();
        check_value({name, " strobes"}, count, strobe_count - strobes_before);
        check_value({name, " bursts"}, (count > 0) ? 1 : 0, strobe_runs - runs_before);
        tx_req = 1'b0;
        while (tx_ack) sys_step();
    endtask

    initial begin
        logic valid_q;
        strobe_count = 0;
        strobe_runs  = 0;
        valid_q      = 1'b0;
        forever begin
            @(posedge phy_tx_clk);
            #DRIVE;
            if (phy_tx_valid) begin
                strobe_count++;
                if (!valid_q) strobe_runs++;
            end
            valid_q = phy_tx_valid;
        end
    end

    initial begin
        forever begin
            sys_step();
            if (u_dut.u_host_ctrl.u_asserts.fail_count != 0) begin
                $display("A handshake assertion failed in the host controller");
                abort_run();
            end
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Watchdog expired after %0d ns before the trace was done", limit_ns);
        abort_run();
    end

    initial begin
        string name;
        arst_n       = 1'b0;
        arm_req      = 1'b0;
        arm_slot     = '0;
        frame_ack    = 1'b0;
        tx_req       = 1'b0;
        tx_count     = '0;
        phy_rx_valid = 1'b0;
        phy_rx_last  = 1'b0;
        lfsr         = 32'h151de0e3;
        load_trace();
        repeat (5) @(posedge clk2);
        #DRIVE;
        arst_n = 1'b1;
        check_value("reset arm_ack", 0, int'(arm_ack));
        check_value("reset tx_ack", 0, int'(tx_ack));
        check_value("reset frame_req", 0, int'(frame_req));
        check_value("reset phy_tx_valid", 0, int'(phy_tx_valid));
        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("op %0d %c", i, op_q[i]);
            case (op_q[i])
                "A": arm_slot_hs(a_q[i]);
                "R": begin
                    receive_bytes(a_q[i]);
                    expect_frame(name, b_q[i], a_q[i], 0);
                end
                "D": begin
                    receive_bytes(a_q[i]);
                    expect_silence(name);
                end
                "T": transmit_frame(name, a_q[i]);
                "P": begin
                    receive_bytes(a_q[i]);
                    receive_bytes(b_q[i]);
                    expect_frame({name, " first"}, 0, a_q[i], c_q[i]);
                    expect_frame({name, " second"}, 1, b_q[i], 0);
                end
                default: begin
                    $display("Unknown operation %c in the trace file", op_q[i]);
                    abort_run();
                end
            endcase
        end
        repeat (10) sys_step();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- testbench/mac_sync_trace.txt
# Columns: op a b c. A slot = arm a slot. R count slot = receive, expect that slot
# D count = receive with no slot armed. T count = transmit. P count0 count1 ack_delay
A 0
R 12 0
T 5
T 0
D 7
A 1
R 9 1
A 0
A 1
P 20 33 0
A 0
A 1
P 6 41 25
T 64

//--- src.f
verilog/mac_frame_pkg.sv
verilog/mac_ctrl_pkg.sv
verilog/mac_pulse_sync.sv
verilog/mac_domain_sync.sv
verilog/mac_rx_engine.sv
verilog/mac_tx_engine.sv
verilog/mac_host_ctrl.sv
verilog/mac_sync_top.sv
testbench/mac_sync_asserts.sv
testbench/tb_mac_sync.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mac_sync
FILELIST   := src.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
